/* project.f */
+incdir+verilog
verilog/core_pkg.sv
verilog/control_bus.sv
verilog/instr_receiver.sv
verilog/instr_decoder.sv
verilog/control_pipeline.sv
verilog/scalar_execute.sv
verilog/result_sender.sv
verilog/scalar_core.sv
tests/scalar_core_props.sv
tests/scalar_core_tb.sv

/* Bender.yml */
package:
  name: scalar_core

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/core_pkg.sv
      - verilog/control_bus.sv
      - verilog/instr_receiver.sv
      - verilog/instr_decoder.sv
      - verilog/control_pipeline.sv
      - verilog/scalar_execute.sv
      - verilog/result_sender.sv
      - verilog/scalar_core.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tests/scalar_core_props.sv
      - tests/scalar_core_tb.sv

/* tests/scalar_core_tb.sv */
`include "core_params.svh"

module scalar_core_tb;
        timeunit 1ns;
        timeprecision 1ps;
        import core_pkg::*;

        localparam int N_LOAD         = 8;
        localparam int N_ALU          = 40;
        localparam int N_BACK         = 16;
        localparam int N_UNDEF        = 4;
        localparam int INSTR_COUNT    = N_LOAD + N_ALU + N_BACK + 2 * N_UNDEF + 2;
        localparam int TIMEOUT_CYCLES = INSTR_COUNT * 40 + 200;
        localparam int REFUSE_WAIT    = 30;

        logic     clk = 1'b0;
        logic     rst_n;
        logic     in_req;
        instr_t   in_data;
        logic     in_ack;
        logic     out_req;
        logic     out_ack;
        reg_idx_t out_reg;
        data_t    out_data;
        logic     halted;

        integer   seed = 89;
        int       value_errors = 0;
        int       other_errors = 0;
        int       packets_seen = 0;
        int       ack_extra = 0;

        // reference model state
        data_t    model_regs [`REG_COUNT];
        reg_idx_t exp_reg_q [$];
        data_t    exp_data_q [$];

        scalar_core i_scalar_core (.clk, .rst_n, .in_req, .in_data, .in_ack, .out_req,
                .out_ack, .out_reg, .out_data, .halted);

        initial begin
                forever #10 clk = ~clk;
        end

        function automatic instr_t make_rrr(input opcode_t op, input reg_idx_t rd,
                        input reg_idx_t rs1, input reg_idx_t rs2);
                return {op, rd, rs1, rs2, 3'b000};
        endfunction

        function automatic instr_t make_li(input reg_idx_t rd, input imm_t imm);
                return {OP_LI, rd, 1'b0, imm};
        endfunction

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // reference model, one instruction at a time in issue order
        task automatic apply_model(input instr_t w);
                opcode_t  op;
                reg_idx_t rd;
                data_t    x;
                data_t    y;
                data_t    r;
                logic     writes;
                op     = w[15:12];
                rd     = w[11:9];
                x      = model_regs[w[8:6]];
                y      = model_regs[w[5:3]];
                r      = '0;
                writes = 1'b1;
                case (op)
                OP_ADD: r = x + y;
                OP_SUB: r = x - y;
                OP_AND: r = x & y;
                OP_OR:  r = x | y;
                OP_XOR: r = x ^ y;
                OP_SHL: r = x << y[3:0];
                OP_LI:  r = data_t'(w[7:0]);
                default: writes = 1'b0;
                endcase
                if (writes) begin
                        model_regs[rd] = r;
                        exp_reg_q.push_back(rd);
                        exp_data_q.push_back(r);
                end
        endtask

        task automatic send_instr(input instr_t w);
                apply_model(w);
                @(negedge clk);
                in_data = w;
                in_req  = 1'b1;
                @(negedge clk);
                while (!in_ack) @(negedge clk);
                in_req = 1'b0;
                @(negedge clk);
                while (in_ack) @(negedge clk);
        endtask

        task automatic expect_low(input string name, input logic value);
                assert (value === 1'b0) else begin
                        value_errors++;
                        $display("FAILED at %0t: %s expected 0, got %b", $time, name, value);
                end
        endtask

        task automatic check_packet();
                reg_idx_t exp_reg;
                data_t    exp_data;
                packets_seen++;
                assert (exp_reg_q.size() > 0) else begin
                        other_errors++;
                        $display("%0t: a result for r%0d arrived when none was expected",
                                $time, out_reg);
                end
                if (exp_reg_q.size() > 0) begin
                        exp_reg  = exp_reg_q.pop_front();
                        exp_data = exp_data_q.pop_front();
                        assert (out_reg === exp_reg) else begin
                                value_errors++;
                                $display("FAILED at %0t: out_reg expected %0d, got %0d",
                                        $time, exp_reg, out_reg);
                        end
                        assert (out_data === exp_data) else begin
                                value_errors++;
                                $display("FAILED at %0t: out_data expected %h, got %h",
                                        $time, exp_data, out_data);
                        end
                end
        endtask

        task automatic wait_drain();
                while (exp_reg_q.size() > 0) @(negedge clk);
        endtask

        task automatic print_counts();
                $display("errors: %0d value, %0d protocol, %0d other, %0d packets seen",
                        value_errors, i_scalar_core.i_scalar_core_props.fail_count,
                        other_errors, packets_seen);
        endtask

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // result sink with a random ack delay
        initial begin : result_sink
                int delay;
                forever begin
                        @(negedge clk);
                        if (out_req) begin
                                check_packet();
                                delay = $unsigned($random(seed)) % 6 + ack_extra;
                                repeat (delay) @(negedge clk);
                                out_ack = 1'b1;
                                while (out_req) @(negedge clk);
                                out_ack = 1'b0;
                        end
                end
        end

        initial begin : watchdog
                repeat (TIMEOUT_CYCLES) @(posedge clk);
                $display("timeout after %0d cycles, the run did not complete", TIMEOUT_CYCLES);
                print_counts();
                $display("** FAIL **");
                $finish;
        end

        initial begin : main
                opcode_t  op;
                reg_idx_t rd;
                int       waited;
                int       prop_errors;
                rst_n   = 1'b0;
                in_req  = 1'b0;
                in_data = '0;
                out_ack = 1'b0;
                for (int i = 0; i < `REG_COUNT; i++)
                        model_regs[i] = '0;
                repeat (2) @(negedge clk);
                rst_n = 1'b1;

                // reset state, and the core stays quiet without input
                @(negedge clk);
                expect_low("in_ack", in_ack);
                expect_low("out_req", out_req);
                expect_low("halted", halted);
                repeat (10) @(negedge clk);

                for (int i = 0; i < N_LOAD; i++)
                        send_instr(make_li(reg_idx_t'(i), imm_t'($random(seed))));
                wait_drain();

                for (int i = 0; i < N_ALU; i++) begin
                        op = opcode_t'($unsigned($random(seed)) % 6);
                        send_instr(make_rrr(op, reg_idx_t'($random(seed)),
                                reg_idx_t'($random(seed)), reg_idx_t'($random(seed))));
                end
                wait_drain();

                // slow sink so the sender, the stage and the buffer all fill up
                ack_extra = 12;
                for (int i = 0; i < N_BACK; i++) begin
                        op = opcode_t'($unsigned($random(seed)) % 6);
                        send_instr(make_rrr(op, reg_idx_t'($random(seed)),
                                reg_idx_t'($random(seed)), reg_idx_t'($random(seed))));
                end
                wait_drain();
                ack_extra = 0;

                // an undefined opcode aimed at rd, then an ADD that reads rd back
                for (int i = 0; i < N_UNDEF; i++) begin
                        op = opcode_t'(7 + $unsigned($random(seed)) % 8);
                        rd = reg_idx_t'($random(seed));
                        send_instr(make_rrr(op, rd, rd, rd));
                        send_instr(make_rrr(OP_ADD, rd + 3'd1, rd, rd));
                end
                wait_drain();

                send_instr({OP_HALT, 12'h000});
                waited = 0;
                while (!halted && waited < 20) begin
                        @(negedge clk);
                        waited++;
                end
                assert (halted) else begin
                        other_errors++;
                        $display("%0t: halted did not rise after HALT was accepted", $time);
                end

                // a word offered after HALT must never be acknowledged
                in_data = make_li(3'd1, 8'h5a);
                in_req  = 1'b1;
                repeat (REFUSE_WAIT) begin
                        @(negedge clk);
                        expect_low("in_ack", in_ack);
                end
                in_req = 1'b0;

                repeat (10) @(negedge clk);
                assert (exp_reg_q.size() == 0) else begin
                        other_errors++;
                        $display("%0d expected results never arrived", exp_reg_q.size());
                end
                prop_errors = i_scalar_core.i_scalar_core_props.fail_count;
                print_counts();
                if (value_errors == 0 && other_errors == 0 && prop_errors == 0) begin
                        $display("** PASS **");
                end else begin
                        $display("** FAIL **");
                end
                $finish;
        end

endmodule

/* tests/scalar_core_props.sv */
module scalar_core_props (
        input logic               clk,
        input logic               rst_n,
        input logic               in_req,
        input logic               in_ack,
        input logic               out_req,
        input logic               out_ack,
        input core_pkg::reg_idx_t out_reg,
        input core_pkg::data_t    out_data,
        input logic               halted
);
        timeunit 1ns;
        timeprecision 1ps;

        int fail_count = 0;

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // reset values
        reset_outputs_low: assert property (
                @(posedge clk) !rst_n |=> !in_ack && !out_req
        ) else begin
                fail_count++;
                $error("in_ack or out_req high coming out of reset");
        end

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // instruction channel
        ack_needs_req: assert property (
                @(posedge clk) disable iff (!rst_n)
                !in_ack && !in_req |=> !in_ack
        ) else begin
                fail_count++;
                $error("in_ack rose while in_req was low");
        end

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // result channel
        req_held_until_ack: assert property (
                @(posedge clk) disable iff (!rst_n)
                out_req && !out_ack |=> out_req
        ) else begin
                fail_count++;
                $error("out_req dropped before out_ack");
        end

        // the packet may not change under a raised request
        payload_stable: assert property (
                @(posedge clk) disable iff (!rst_n)
                out_req |=> !out_req || ($stable(out_reg) && $stable(out_data))
        ) else begin
                fail_count++;
                $error("out_reg or out_data changed while out_req was high");
        end

        // halted is sticky until the next reset
        halted_sticky: assert property (
                @(posedge clk) disable iff (!rst_n)
                halted |=> halted
        ) else begin
                fail_count++;
                $error("halted fell without a reset");
        end

endmodule

bind scalar_core scalar_core_props i_scalar_core_props (.*);

/* verilog/scalar_core.sv */
module scalar_core (
        input  logic               clk,
        input  logic               rst_n,
        input  logic               in_req,
        input  core_pkg::instr_t   in_data,
        output logic               in_ack,
        output logic               out_req,
        input  logic               out_ack,
        output core_pkg::reg_idx_t out_reg,
        output core_pkg::data_t    out_data,
        output logic               halted
);
        import core_pkg::*;

        instr_t   instr;
        logic     instr_valid;
        logic     stall;
        logic     sender_ready;
        logic     result_valid;
        reg_idx_t result_reg;
        data_t    result_data;

        control_bus control_d_bus ();
        control_bus control_q_bus ();

        instr_receiver i_instr_receiver (.clk, .rst_n, .in_req, .in_data, .in_ack, .halted,
                .stall, .instr, .instr_valid);

        instr_decoder i_instr_decoder (.instr, .instr_valid, .control_d(control_d_bus));

        control_pipeline i_control_pipeline (.clk, .rst_n, .stall,
                .control_d(control_d_bus), .control_q(control_q_bus));

        scalar_execute i_scalar_execute (.clk, .rst_n, .control_q(control_q_bus),
                .sender_ready, .stall, .halted, .result_valid, .result_reg, .result_data);

        result_sender i_result_sender (.clk, .rst_n, .result_valid, .result_reg, .result_data,
                .sender_ready, .out_req, .out_ack, .out_reg, .out_data);

endmodule

/* verilog/result_sender.sv */
module result_sender (
        input  logic               clk,
        input  logic               rst_n,
        input  logic               result_valid,
        input  core_pkg::reg_idx_t result_reg,
        input  core_pkg::data_t    result_data,
        output logic               sender_ready,
        output logic               out_req,
        input  logic               out_ack,
        output core_pkg::reg_idx_t out_reg,
        output core_pkg::data_t    out_data
);
        import core_pkg::*;

        tx_state_t state;
        logic      take;

        assign sender_ready = (state == TX_IDLE);
        assign out_req      = (state == TX_REQ);
        assign take         = sender_ready && result_valid;

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        state <= TX_IDLE;
                end else begin
                        case (state)
                        TX_IDLE: if (take) state <= TX_REQ;
                        TX_REQ: if (out_ack) state <= TX_WAIT_RELEASE;
                        // the sink must drop out_ack before the next result goes out
                        TX_WAIT_RELEASE: if (!out_ack) state <= TX_IDLE;
                        default: state <= TX_IDLE;
                        endcase
                end
        end

        // holding register stays put for the whole exchange
        always_ff @(posedge clk) begin
                if (take) begin
                        out_reg  <= result_reg;
                        out_data <= result_data;
                end
        end

endmodule

/* verilog/scalar_execute.sv */
`include "core_params.svh"

module scalar_execute (
        input  logic               clk,
        input  logic               rst_n,
        control_bus.sink           control_q,
        input  logic               sender_ready,
        output logic               stall,
        output logic               halted,
        output logic               result_valid,
        output core_pkg::reg_idx_t result_reg,
        output core_pkg::data_t    result_data
);
        import core_pkg::*;

        data_t regs [`REG_COUNT];
        data_t src1;
        data_t src2;
        data_t alu_out;
        data_t imm_ext;
        logic  writing;

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // issue control
        // only a writing instruction needs the sender, so HALT and no-ops never stall
        assign writing      = control_q.valid && control_q.register_wr_en;
        assign stall        = writing && !sender_ready;
        assign result_valid = writing && sender_ready;

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // operand read and ALU
        assign src1 = regs[control_q.scalar_read_register1];
        assign src2 = regs[control_q.scalar_read_register2];

        always_comb begin
                case (control_q.scalar_alu_op)
                ALU_ADD: alu_out = src1 + src2;
                ALU_SUB: alu_out = src1 - src2;
                ALU_AND: alu_out = src1 & src2;
                ALU_OR:  alu_out = src1 | src2;
                ALU_XOR: alu_out = src1 ^ src2;
                // shift amount is the low nibble of rs2
                ALU_SHL: alu_out = src1 << src2[3:0];
                default: alu_out = '0;
                endcase
        end

        assign imm_ext     = {{(`DATA_W - `IMM_W){1'b0}}, control_q.imm};
        assign result_data = control_q.store_immediate ? imm_ext : alu_out;
        assign result_reg  = control_q.scalar_write_register;

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // writeback and halt
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        for (int i = 0; i < `REG_COUNT; i++)
                                regs[i] <= '0;
                end else if (result_valid) begin
                        regs[control_q.scalar_write_register] <= result_data;
                end
        end

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n)
                        halted <= 1'b0;
                else if (control_q.valid && control_q.halt)
                        halted <= 1'b1;
        end

endmodule

/* verilog/control_pipeline.sv */
module control_pipeline (
        input  logic      clk,
        input  logic      rst_n,
        input  logic      stall,
        control_bus.sink  control_d,
        control_bus.drive control_q
);

        // the whole bundle advances together or holds together
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        control_q.valid                 <= '0;
                        control_q.halt                  <= '0;
                        control_q.register_wr_en        <= '0;
                        control_q.store_immediate       <= '0;
                        control_q.scalar_alu_op         <= '0;
                        control_q.scalar_write_register <= '0;
                        control_q.scalar_read_register1 <= '0;
                        control_q.scalar_read_register2 <= '0;
                        control_q.imm                   <= '0;
                end else if (!stall) begin
                        control_q.valid                 <= control_d.valid;
                        control_q.halt                  <= control_d.halt;
                        control_q.register_wr_en        <= control_d.register_wr_en;
                        control_q.store_immediate       <= control_d.store_immediate;
                        control_q.scalar_alu_op         <= control_d.scalar_alu_op;
                        control_q.scalar_write_register <= control_d.scalar_write_register;
                        control_q.scalar_read_register1 <= control_d.scalar_read_register1;
                        control_q.scalar_read_register2 <= control_d.scalar_read_register2;
                        control_q.imm                   <= control_d.imm;
                end
        end

endmodule

/* verilog/instr_decoder.sv */
module instr_decoder (
        input  core_pkg::instr_t instr,
        input  logic             instr_valid,
        control_bus.drive        control_d
);
        import core_pkg::*;

        opcode_t opcode;

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // field extraction
        // opcode 15:12, rd 11:9, rs1 8:6, rs2 5:3, imm 7:0
        assign opcode = instr[15:12];

        assign control_d.valid                 = instr_valid;
        assign control_d.scalar_write_register = instr[11:9];
        assign control_d.scalar_read_register1 = instr[8:6];
        assign control_d.scalar_read_register2 = instr[5:3];
        assign control_d.imm                   = instr[7:0];

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // opcode to control mapping
        always_comb begin
                control_d.scalar_alu_op   = ALU_ADD;
                control_d.register_wr_en  = 1'b0;
                control_d.store_immediate = 1'b0;
                control_d.halt            = 1'b0;
                case (opcode)
                OP_ADD: begin
                        control_d.scalar_alu_op  = ALU_ADD;
                        control_d.register_wr_en = 1'b1;
                end
                OP_SUB: begin
                        control_d.scalar_alu_op  = ALU_SUB;
                        control_d.register_wr_en = 1'b1;
                end
                OP_AND: begin
                        control_d.scalar_alu_op  = ALU_AND;
                        control_d.register_wr_en = 1'b1;
                end
                OP_OR: begin
                        control_d.scalar_alu_op  = ALU_OR;
                        control_d.register_wr_en = 1'b1;
                end
                OP_XOR: begin
                        control_d.scalar_alu_op  = ALU_XOR;
                        control_d.register_wr_en = 1'b1;
                end
                OP_SHL: begin
                        control_d.scalar_alu_op  = ALU_SHL;
                        control_d.register_wr_en = 1'b1;
                end
                OP_LI: begin
                        control_d.store_immediate = 1'b1;
                        control_d.register_wr_en  = 1'b1;
                end
                OP_HALT: begin
                        control_d.halt = 1'b1;
                end
                // anything else flows through as a no-op
                default: ;
                endcase
        end

endmodule

/* verilog/instr_receiver.sv */
module instr_receiver (
        input  logic             clk,
        input  logic             rst_n,
        input  logic             in_req,
        input  core_pkg::instr_t in_data,
        output logic             in_ack,
        input  logic             halted,
        input  logic             stall,
        output core_pkg::instr_t instr,
        output logic             instr_valid
);
        import core_pkg::*;

        rx_state_t state;
        logic      halt_taken;
        logic      accept;
        logic      keep_word;

        // a HALT that is still in flight closes the channel before halted rises
        assign accept    = (state == RX_IDLE) && in_req && !halted && !halt_taken;
        assign keep_word = instr_valid && stall;
        assign in_ack    = (state == RX_ACK);

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        state       <= RX_IDLE;
                        instr_valid <= 1'b0;
                        halt_taken  <= 1'b0;
                end else begin
                        case (state)
                        RX_IDLE: if (accept) state <= RX_ACK;
                        // wait for the source to drop in_req, then for the buffer to drain
                        RX_ACK: if (!in_req) state <= keep_word ? RX_WAIT_RELEASE : RX_IDLE;
                        RX_WAIT_RELEASE: if (!stall) state <= RX_IDLE;
                        default: state <= RX_IDLE;
                        endcase

                        if (accept) begin
                                instr_valid <= 1'b1;
                                if (opcode_t'(in_data[15:12]) == OP_HALT)
                                        halt_taken <= 1'b1;
                        end else if (!stall) begin
                                instr_valid <= 1'b0;
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (accept)
                        instr <= in_data;
        end

endmodule

/* verilog/control_bus.sv */
interface control_bus;
        import core_pkg::*;

        logic     valid;
        logic     halt;
        logic     register_wr_en;
        logic     store_immediate;
        alu_op_t  scalar_alu_op;
        reg_idx_t scalar_write_register;
        reg_idx_t scalar_read_register1;
        reg_idx_t scalar_read_register2;
        imm_t     imm;

        // the producer of one decoded instruction
        modport drive (
                output valid,
                output halt,
                output register_wr_en,
                output store_immediate,
                output scalar_alu_op,
                output scalar_write_register,
                output scalar_read_register1,
                output scalar_read_register2,
                output imm
        );

        // the consumer of the same bundle
        modport sink (
                input valid,
                input halt,
                input register_wr_en,
                input store_immediate,
                input scalar_alu_op,
                input scalar_write_register,
                input scalar_read_register1,
                input scalar_read_register2,
                input imm
        );

endinterface

/* verilog/core_pkg.sv */
`include "core_params.svh"

package core_pkg;

        typedef logic [`INSTR_W-1:0]   instr_t;
        typedef logic [`DATA_W-1:0]    data_t;
        typedef logic [`REG_IDX_W-1:0] reg_idx_t;
        typedef logic [`IMM_W-1:0]     imm_t;
        typedef logic [3:0]            opcode_t;
        typedef logic [2:0]            alu_op_t;

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // opcode field values
        localparam opcode_t OP_ADD  = 4'd0;
        localparam opcode_t OP_SUB  = 4'd1;
        localparam opcode_t OP_AND  = 4'd2;
        localparam opcode_t OP_OR   = 4'd3;
        localparam opcode_t OP_XOR  = 4'd4;
        localparam opcode_t OP_SHL  = 4'd5;
        localparam opcode_t OP_LI   = 4'd6;
        localparam opcode_t OP_HALT = 4'd15;

        // ALU selections carried in scalar_alu_op
        localparam alu_op_t ALU_ADD = 3'd0;
        localparam alu_op_t ALU_SUB = 3'd1;
        localparam alu_op_t ALU_AND = 3'd2;
        localparam alu_op_t ALU_OR  = 3'd3;
        localparam alu_op_t ALU_XOR = 3'd4;
        localparam alu_op_t ALU_SHL = 3'd5;

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        typedef enum logic [1:0] {
                RX_IDLE,
                RX_ACK,
                RX_WAIT_RELEASE
        } rx_state_t;

        typedef enum logic [1:0] {
                TX_IDLE,
                TX_REQ,
                TX_WAIT_RELEASE
        } tx_state_t;

endpackage

/* verilog/core_params.svh */
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// datapath and instruction word widths
`define DATA_W    16
`define INSTR_W   16

// register file geometry
`define REG_COUNT 8
`define REG_IDX_W 3

// LI carries an immediate that is zero-extended to DATA_W
`define IMM_W     8

`endif
